// ==== verilog.f ====
verilog/apogeo_pkg.sv
verilog/commit_buffer.sv
verilog/step_counter.sv
verilog/shift_add_multiplier.sv
verilog/multiply_control.sv
verilog/register_writeback.sv
verilog/multiply_commit_top.sv
bench/multiply_commit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f verilog.f \
        --top-module multiply_commit_tb -o multiply_commit_sim \
    && ./obj_dir/multiply_commit_sim \
    || { echo "Simulation failed"; exit 1; }

// ==== bench/multiply_commit_tb.sv ====
`timescale 1ns/1ps

module multiply_commit_tb;

    localparam int NUM_OPS = 250;
    // An operation takes about 35 cycles plus grant stalls and 80 per operation leave a wide margin
    localparam int MAX_CYCLES = NUM_OPS * 80;
    localparam logic [15:0] LFSR_SEED = 16'd35424;

    logic                        clk_i = 1'b0;
    logic                        rst_n_i = 1'b0;
    logic                        issue_i = 1'b0;
    apogeo_pkg::mul_op_t         op_i = apogeo_pkg::MUL;
    apogeo_pkg::data_word_t      operand_a_i = '0;
    apogeo_pkg::data_word_t      operand_b_i = '0;
    apogeo_pkg::instr_packet_t   ipacket_i = '0;
    logic                        wb_grant_i = 1'b0;
    logic                        busy_o;
    apogeo_pkg::writeback_port_t wb_port_o;

    apogeo_pkg::writeback_port_t expected_q[$];
    logic [15:0] lfsr_state = LFSR_SEED;
    int          issued = 0;
    int          accepted = 0;
    int          received = 0;
    int          max_outstanding = 0;
    int          cycle_count = 0;
    logic        grant_seen = 1'b0;
    logic        grant_level = 1'b0;
    // Start with a long stretch without grant so the buffer is sure to fill
    int          stretch_left = 300;

    multiply_commit_top dut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .issue_i     (issue_i),
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .ipacket_i   (ipacket_i),
        .busy_o      (busy_o),
        .wb_grant_i  (wb_grant_i),
        .wb_port_o   (wb_port_o)
    );

    always #50 clk_i = ~clk_i;

    // Taps 16, 14, 13 and 11 give a maximal length sequence
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Edge operands show up often enough to be exercised with every opcode
    function automatic apogeo_pkg::data_word_t pick_operand();
        logic [31:0] sel;
        sel = take_bits(3);
        case (sel)
            32'd0:   return 32'h0000_0000;
            32'd1:   return 32'hffff_ffff;
            32'd2:   return 32'h8000_0000;
            default: return take_bits(32);
        endcase
    endfunction

    // Reference product taken straight from the RISC-V definition of each opcode
    function automatic apogeo_pkg::data_word_t expected_result(input apogeo_pkg::mul_op_t op,
                                                               input apogeo_pkg::data_word_t a,
                                                               input apogeo_pkg::data_word_t b);
        logic signed [63:0] signed_prod;
        logic [63:0]        unsigned_prod;
        signed_prod   = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        unsigned_prod = {32'b0, a} * {32'b0, b};
        case (op)
            apogeo_pkg::MUL:  return signed_prod[31:0];
            apogeo_pkg::MULH: return signed_prod[63:32];
            default:          return unsigned_prod[63:32];
        endcase
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_port(input apogeo_pkg::writeback_port_t actual,
                              input apogeo_pkg::writeback_port_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at %0t: writeback x%0d = %h, expected x%0d = %h",
                                $time, actual.reg_dest, actual.result,
                                expected.reg_dest, expected.result));
        end
    endtask

    task automatic check_level(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at %0t: %s is %b, expected %b",
                                $time, what, actual, expected));
        end
    endtask

    task automatic drive_issue();
        apogeo_pkg::mul_op_t         op;
        apogeo_pkg::data_word_t      a;
        apogeo_pkg::data_word_t      b;
        apogeo_pkg::instr_packet_t   packet;
        apogeo_pkg::writeback_port_t expected;
        logic [31:0]                 code;
        logic [31:0]                 dest;
        code = take_bits(2);
        if (code == 32'd1) begin
            op = apogeo_pkg::MULH;
        end else if (code == 32'd2) begin
            op = apogeo_pkg::MULHU;
        end else begin
            op = apogeo_pkg::MUL;
        end
        a = pick_operand();
        b = pick_operand();
        dest = take_bits(5);
        packet.instr_addr = take_bits(32);
        packet.reg_dest = dest[4:0];
        expected.valid = 1'b1;
        expected.reg_dest = packet.reg_dest;
        expected.result = expected_result(op, a, b);
        expected_q.push_back(expected);
        issued = issued + 1;
        op_i        <= op;
        operand_a_i <= a;
        operand_b_i <= b;
        ipacket_i   <= packet;
        issue_i     <= 1'b1;
    endtask

    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            abort_run($sformatf("Timeout: the run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    // Outputs are checked mid-cycle, away from the clock edge
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (wb_port_o.valid) begin
                if (!grant_seen) begin
                    abort_run("A register write appeared without a grant in the cycle before");
                end
                if (expected_q.size() == 0) begin
                    abort_run("A register write appeared with no result outstanding");
                end
                check_port(wb_port_o, expected_q.pop_front());
                received = received + 1;
            end
            if (accepted - received > apogeo_pkg::COMMIT_DEPTH + 1) begin
                abort_run("More results are held than the buffer and the control can store");
            end
            if (accepted - received > apogeo_pkg::COMMIT_DEPTH) begin
                check_level(busy_o, 1'b1, "busy_o with the commit buffer full");
            end
            if (accepted - received > max_outstanding) begin
                max_outstanding = accepted - received;
            end
        end
        grant_seen = wb_grant_i;
    end

    initial begin
        repeat (7) @(posedge clk_i);
        @(negedge clk_i);
        check_level(busy_o, 1'b0, "busy_o in reset");
        check_level(wb_port_o.valid, 1'b0, "writeback valid in reset");
        @(posedge clk_i);
        rst_n_i <= 1'b1;

        while (received < NUM_OPS) begin
            @(posedge clk_i);
            if (stretch_left == 0) begin
                stretch_left = 1 + int'(take_bits(8));
                grant_level = (take_bits(1) != 0);
            end
            stretch_left = stretch_left - 1;
            // Once every operation is issued the grant stays high to drain the buffer
            wb_grant_i <= grant_level || (issued == NUM_OPS);
            if (issue_i) begin
                issue_i <= 1'b0;
                accepted = accepted + 1;
            end else if (!busy_o && issued < NUM_OPS) begin
                drive_issue();
            end
        end
        repeat (5) @(posedge clk_i);

        if (expected_q.size() == 0 && accepted == NUM_OPS && received == NUM_OPS &&
            max_outstanding == apogeo_pkg::COMMIT_DEPTH + 1) begin
            $display("All tests passed!");
            $finish;
        end else begin
            abort_run($sformatf("Run ended with %0d accepted, %0d written, peak occupancy %0d",
                                accepted, received, max_outstanding));
        end
    end

endmodule : multiply_commit_tb

// ==== verilog/multiply_commit_top.sv ====
`timescale 1ns/1ps

module multiply_commit_top (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        issue_i,
    input  apogeo_pkg::mul_op_t         op_i,
    input  apogeo_pkg::data_word_t      operand_a_i,
    input  apogeo_pkg::data_word_t      operand_b_i,
    input  apogeo_pkg::instr_packet_t   ipacket_i,
    output logic                        busy_o,
    input  logic                        wb_grant_i,
    output apogeo_pkg::writeback_port_t wb_port_o
);

    logic start;
    logic step;
    logic count_clear;
    logic count_enable;
    logic last_step;
    logic buffer_write;
    logic buffer_read;
    logic buffer_full;
    logic buffer_empty;

    apogeo_pkg::data_word_t    mul_result;
    apogeo_pkg::instr_packet_t ctrl_packet;
    apogeo_pkg::data_word_t    head_result;
    apogeo_pkg::instr_packet_t head_packet;

    multiply_control u_control (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .issue_i        (issue_i),
        .ipacket_i      (ipacket_i),
        .buffer_full_i  (buffer_full),
        .last_step_i    (last_step),
        .start_o        (start),
        .step_o         (step),
        .count_clear_o  (count_clear),
        .count_enable_o (count_enable),
        .buffer_write_o (buffer_write),
        .ipacket_o      (ctrl_packet),
        .busy_o         (busy_o)
    );

    step_counter u_counter (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .clear_i  (count_clear),
        .enable_i (count_enable),
        .last_o   (last_step)
    );

    shift_add_multiplier u_multiplier (
        .clk_i       (clk_i),
        .start_i     (start),
        .step_i      (step),
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .result_o    (mul_result)
    );

    commit_buffer #(
        .BUFFER_DEPTH (apogeo_pkg::COMMIT_DEPTH)
    ) u_buffer (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .write_i   (buffer_write),
        .read_i    (buffer_read),
        .result_i  (mul_result),
        .ipacket_i (ctrl_packet),
        .result_o  (head_result),
        .ipacket_o (head_packet),
        .full_o    (buffer_full),
        .empty_o   (buffer_empty)
    );

    register_writeback u_writeback (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .grant_i        (wb_grant_i),
        .buffer_empty_i (buffer_empty),
        .result_i       (head_result),
        .ipacket_i      (head_packet),
        .buffer_read_o  (buffer_read),
        .wb_port_o      (wb_port_o)
    );

endmodule : multiply_commit_top

// ==== verilog/register_writeback.sv ====
`timescale 1ns/1ps

module register_writeback (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        grant_i,
    input  logic                        buffer_empty_i,
    input  apogeo_pkg::data_word_t      result_i,
    input  apogeo_pkg::instr_packet_t   ipacket_i,
    output logic                        buffer_read_o,
    output apogeo_pkg::writeback_port_t wb_port_o
);

    // Pop the head whenever the register file offers a port
    assign buffer_read_o = grant_i && !buffer_empty_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_port_o.valid <= 1'b0;
        end else begin
            wb_port_o.valid <= buffer_read_o;
        end
        // Destination and data are loaded on a pop and held until the next one
        if (buffer_read_o) begin
            wb_port_o.reg_dest <= ipacket_i.reg_dest;
            wb_port_o.result   <= result_i;
        end
    end

endmodule : register_writeback

// ==== verilog/multiply_control.sv ====
`timescale 1ns/1ps

module multiply_control (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      issue_i,
    input  apogeo_pkg::instr_packet_t ipacket_i,
    input  logic                      buffer_full_i,
    input  logic                      last_step_i,
    output logic                      start_o,
    output logic                      step_o,
    output logic                      count_clear_o,
    output logic                      count_enable_o,
    output logic                      buffer_write_o,
    output apogeo_pkg::instr_packet_t ipacket_o,
    output logic                      busy_o
);

    apogeo_pkg::mul_state_t    state;
    apogeo_pkg::mul_state_t    state_next;
    apogeo_pkg::instr_packet_t packet_q;

    always_comb begin
        state_next = state;
        case (state)
            apogeo_pkg::IDLE: begin
                if (issue_i) begin
                    state_next = apogeo_pkg::COMPUTE;
                end
            end
            apogeo_pkg::COMPUTE: begin
                if (last_step_i) begin
                    state_next = apogeo_pkg::COMMIT;
                end
            end
            apogeo_pkg::COMMIT: begin
                // Stay here while the buffer has no room
                if (!buffer_full_i) begin
                    state_next = apogeo_pkg::IDLE;
                end
            end
            default: state_next = apogeo_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state  <= apogeo_pkg::IDLE;
            busy_o <= 1'b0;
        end else begin
            state  <= state_next;
            busy_o <= (state_next != apogeo_pkg::IDLE);
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_o) begin
            packet_q <= ipacket_i;
        end
    end

    // Issue is only honoured from IDLE
    assign start_o        = (state == apogeo_pkg::IDLE) && issue_i;
    assign count_clear_o  = start_o;
    assign step_o         = (state == apogeo_pkg::COMPUTE);
    assign count_enable_o = step_o;
    assign buffer_write_o = (state == apogeo_pkg::COMMIT) && !buffer_full_i;
    assign ipacket_o      = packet_q;

    // The counter must only reach its final step while the datapath is iterating
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
                     last_step_i |-> state == apogeo_pkg::COMPUTE)
        else $error("step counter reached last step outside COMPUTE");

endmodule : multiply_control

// ==== verilog/shift_add_multiplier.sv ====
`timescale 1ns/1ps

module shift_add_multiplier (
    input  logic                    clk_i,
    input  logic                    start_i,
    input  logic                    step_i,
    input  apogeo_pkg::mul_op_t     op_i,
    input  apogeo_pkg::data_word_t  operand_a_i,
    input  apogeo_pkg::data_word_t  operand_b_i,
    output apogeo_pkg::data_word_t  result_o
);

    logic                   signed_op;
    apogeo_pkg::data_word_t mag_a;
    apogeo_pkg::data_word_t mag_b;

    apogeo_pkg::data_word_t multiplicand;
    logic [63:0]            product;
    logic                   negate;
    apogeo_pkg::mul_op_t    op_q;

    logic [32:0]            partial_sum;
    logic [63:0]            signed_product;

    // MUL shares the signed path since the low half does not depend on signedness
    assign signed_op = (op_i != apogeo_pkg::MULHU);

    assign mag_a = (signed_op && operand_a_i[31]) ? -operand_a_i : operand_a_i;
    assign mag_b = (signed_op && operand_b_i[31]) ? -operand_b_i : operand_b_i;

    // Upper half plus multiplicand, with the carry kept for the shift
    assign partial_sum = product[0] ? {1'b0, product[63:32]} + {1'b0, multiplicand}
                                    : {1'b0, product[63:32]};

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            multiplicand <= mag_a;
            product      <= {32'b0, mag_b};
            negate       <= signed_op && (operand_a_i[31] ^ operand_b_i[31]);
            op_q         <= op_i;
        end else if (step_i) begin
            // The multiplier bit just used drops out at the bottom
            product <= {partial_sum, product[31:1]};
        end
    end

    assign signed_product = negate ? -product : product;

    always_comb begin
        case (op_q)
            apogeo_pkg::MUL: result_o = signed_product[31:0];
            default:         result_o = signed_product[63:32];
        endcase
    end

endmodule : shift_add_multiplier

// ==== verilog/step_counter.sv ====
`timescale 1ns/1ps

module step_counter (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic clear_i,
    input  logic enable_i,
    output logic last_o
);

    localparam logic [apogeo_pkg::STEP_CNT_BITS-1:0] LAST_STEP =
        apogeo_pkg::STEP_CNT_BITS'(apogeo_pkg::MUL_STEPS - 1);

    logic [apogeo_pkg::STEP_CNT_BITS-1:0] count;

    // Clear wins over enable so a new operation always starts from zero
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count <= '0;
        end else if (clear_i) begin
            count <= '0;
        end else if (enable_i) begin
            count <= count + 1'b1;
        end
    end

    // High during the final iteration before the count wraps back to zero
    assign last_o = (count == LAST_STEP);

endmodule : step_counter

// ==== verilog/commit_buffer.sv ====
`timescale 1ns/1ps

module commit_buffer #(
    parameter int BUFFER_DEPTH = 8
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,

    input  logic                      write_i,
    input  logic                      read_i,

    input  apogeo_pkg::data_word_t    result_i,
    input  apogeo_pkg::instr_packet_t ipacket_i,

    output apogeo_pkg::data_word_t    result_o,
    output apogeo_pkg::instr_packet_t ipacket_o,

    output logic                      full_o,
    output logic                      empty_o
);

    localparam int PTR_BITS = $clog2(BUFFER_DEPTH);
    localparam int ENTRY_BITS = $bits(apogeo_pkg::data_word_t)
                              + $bits(apogeo_pkg::instr_packet_t);

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS-1:0] wr_ptr_next;
    logic [PTR_BITS-1:0] rd_ptr_next;

    logic [ENTRY_BITS-1:0] entries [BUFFER_DEPTH];

    // Pointers wrap naturally since the depth is a power of two
    assign wr_ptr_next = wr_ptr + 1'b1;
    assign rd_ptr_next = rd_ptr + 1'b1;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (write_i) begin
                wr_ptr <= wr_ptr_next;
            end
            if (read_i) begin
                rd_ptr <= rd_ptr_next;
            end
        end
    end

    // A simultaneous push and pop leaves the occupancy and so both flags unchanged
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            full_o  <= 1'b0;
            empty_o <= 1'b1;
        end else if (write_i && !read_i) begin
            empty_o <= 1'b0;
            full_o  <= (wr_ptr_next == rd_ptr);
        end else if (read_i && !write_i) begin
            full_o  <= 1'b0;
            empty_o <= (rd_ptr_next == wr_ptr);
        end
    end

    always_ff @(posedge clk_i) begin
        if (write_i) begin
            entries[wr_ptr] <= {result_i, ipacket_i};
        end
    end

    // Head of the buffer is visible without a read cycle
    assign {result_o, ipacket_o} = entries[rd_ptr];

    assert property (@(posedge clk_i) disable iff (!rst_n_i) write_i |-> !full_o)
        else $error("commit buffer written while full");

    assert property (@(posedge clk_i) disable iff (!rst_n_i) read_i |-> !empty_o)
        else $error("commit buffer read while empty");

endmodule : commit_buffer

// ==== verilog/apogeo_pkg.sv ====
package apogeo_pkg;

    // Width of the integer datapath and of every result word
    typedef logic [31:0] data_word_t;

    // Architectural register index
    typedef logic [4:0] reg_addr_t;

    // Companion data carried next to each result until it is written back
    typedef struct packed {
        data_word_t instr_addr;
        reg_addr_t  reg_dest;
    } instr_packet_t;

    // Multiply opcodes with RISC-V meaning
    typedef enum logic [1:0] {
        MUL,
        MULH,
        MULHU
    } mul_op_t;

    // Multiply control states
    typedef enum logic [1:0] {
        IDLE,
        COMPUTE,
        COMMIT
    } mul_state_t;

    // One register file write port
    typedef struct packed {
        logic       valid;
        reg_addr_t  reg_dest;
        data_word_t result;
    } writeback_port_t;

    // One iteration per multiplier bit
    localparam int MUL_STEPS = 32;
    localparam int STEP_CNT_BITS = 5;

    // Kept small so back-pressure fills the buffer quickly
    localparam int COMMIT_DEPTH = 4;

endpackage : apogeo_pkg
